// File: rtl/cpu_ctrl.sv
`timescale 1ns/1ps

module cpu_ctrl (
	input  logic                      clk,
	input  logic                      n_reset,
	input  logic                      ipram_loaded,
	input  cpu_ctrl_pkg::int_ctl_t    int_ctl,
	input  cpu_ctrl_pkg::int_req_t    int_req,
	input  cpu_ctrl_pkg::instr_u      instr,
	input  cpu_ctrl_pkg::flags_t      flags,
	output cpu_ctrl_pkg::halt_t       halt,
	output cpu_ctrl_pkg::int_status_t int_status,
	output cpu_ctrl_pkg::state_e      state
);
	import cpu_ctrl_pkg::*;

	instr_class_e iclass;
	seq_ctl_t     seq_ctl;
	take_t        take;

	op_decoder u_decoder (
		.instr  (instr),
		.flags  (flags),
		.iclass (iclass)
	);

	cycle_sequencer u_sequencer (
		.clk          (clk),
		.n_reset      (n_reset),
		.ipram_loaded (ipram_loaded),
		.iclass       (iclass),
		.take         (take),
		.int_status   (int_status),
		.seq_ctl      (seq_ctl),
		.halt         (halt),
		.state        (state)
	);

	int_controller u_int_ctrl (
		.clk        (clk),
		.n_reset    (n_reset),
		.int_ctl    (int_ctl),
		.int_req    (int_req),
		.seq_ctl    (seq_ctl),
		.take       (take),
		.int_status (int_status)
	);

endmodule

// File: rtl/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	// Machine states, each step is three consecutive codes
	typedef enum logic [5:0] {
		IDLE,
		FETCH_1, FETCH_2, FETCH_3,
		OP1_1, OP1_2, OP1_3,
		OP2_1, OP2_2, OP2_3,
		MEM_READ1_1, MEM_READ1_2, MEM_READ1_3,
		MEM_READ2_1, MEM_READ2_2, MEM_READ2_3,
		MEM_WRITE1_1, MEM_WRITE1_2, MEM_WRITE1_3,
		MEM_WRITE2_1, MEM_WRITE2_2, MEM_WRITE2_3,
		IO_READ_1, IO_READ_2, IO_READ_3,
		IO_WRITE_1, IO_WRITE_2, IO_WRITE_3,
		ACK_INT_1, ACK_INT_2, ACK_INT_3, ACK_INT_4,
		ACK_NMI_1, ACK_NMI_2,
		PRE_FETCH, PRE_MEM_READ_2, PRE_MEM_WRITE_1, PRE_MEM_WRITE_2
	} state_e;

	typedef enum logic [4:0] {
		CL_SIMPLE, CL_HALT,
		CL_IMM8, CL_IMM16, CL_LD_MEM_IMM, CL_IN_N, CL_OUT_N,
		CL_LOAD_ABS8, CL_LOAD_ABS16, CL_STORE_ABS8, CL_STORE_ABS16,
		CL_CALL, CL_SKIP_CALL,
		CL_READ8, CL_POP, CL_RET, CL_RMW, CL_EX_SP,
		CL_PUSH, CL_WRITE8
	} instr_class_e;

	typedef enum logic [1:0] {
		IM0 = 2'd0,
		IM1 = 2'd1
	} int_mode_e;

	typedef struct packed {
		logic [1:0] x;
		logic [2:0] y; // Condition code, ALU op or register
		logic [2:0] z;
	} instr_xyz_t;

	typedef struct packed {
		logic [1:0] x;
		logic [1:0] p; // Register pair
		logic       q;
		logic [2:0] z;
	} instr_xpqz_t;

	typedef union packed {
		logic [7:0]  raw;
		instr_xyz_t  xyz;
		instr_xpqz_t xpqz;
	} instr_u;

	typedef struct packed {
		logic s;
		logic z;
		logic pv;
		logic c;
	} flags_t;

	typedef struct packed {
		logic      dis;         // DI executed
		logic      enable;      // EI executed
		logic      restore;     // RETN, IFF2 back to IFF1
		logic      mode_change;
		int_mode_e mode_next;
	} int_ctl_t;

	typedef struct packed {
		logic nmi;
		logic intr;
	} int_req_t;

	typedef struct packed {
		logic      active_int;
		logic      active_nmi;
		logic      iff2;
		logic      sampled_int;
		logic      sampled_nmi;
		int_mode_e mode;
	} int_status_t;

	typedef struct packed {
		logic sample;   // Latch the request lines
		logic suppress; // Instruction continues, no boundary here
		logic done;     // Acknowledge sequence finished
	} seq_ctl_t;

	typedef struct packed {
		logic nmi;
		logic intr;
	} take_t;

	typedef struct packed {
		logic n_halt;
		logic we;
	} halt_t;

endpackage

// File: rtl/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer (
	input  logic                       clk,
	input  logic                       n_reset,
	input  logic                       ipram_loaded,
	input  cpu_ctrl_pkg::instr_class_e iclass,
	input  cpu_ctrl_pkg::take_t        take,
	input  cpu_ctrl_pkg::int_status_t  int_status,
	output cpu_ctrl_pkg::seq_ctl_t     seq_ctl,
	output cpu_ctrl_pkg::halt_t        halt,
	output cpu_ctrl_pkg::state_e       state
);
	import cpu_ctrl_pkg::*;

	state_e       state_next;
	instr_class_e cls;     // Path being walked
	logic         service; // INT or NMI acknowledge running

	// Where a step goes after its third state
	function automatic state_e step_exit(input state_e s3, input instr_class_e c);
		step_exit = FETCH_1;
		case (s3)
			FETCH_3: begin
				case (c)
					CL_IMM8, CL_IMM16, CL_LD_MEM_IMM, CL_IN_N, CL_OUT_N,
					CL_LOAD_ABS8, CL_LOAD_ABS16, CL_STORE_ABS8, CL_STORE_ABS16,
					CL_CALL: step_exit = OP1_1;
					CL_READ8, CL_POP, CL_RET, CL_RMW, CL_EX_SP: step_exit = MEM_READ1_1;
					CL_WRITE8: step_exit = MEM_WRITE1_1;
					CL_PUSH: step_exit = PRE_MEM_WRITE_1;
					CL_SKIP_CALL: step_exit = PRE_FETCH;
					default: step_exit = FETCH_1;
				endcase
			end
			OP1_3: begin
				case (c)
					CL_IMM16, CL_LOAD_ABS8, CL_LOAD_ABS16, CL_STORE_ABS8,
					CL_STORE_ABS16, CL_CALL: step_exit = OP2_1;
					CL_LD_MEM_IMM: step_exit = MEM_WRITE1_1;
					CL_IN_N: step_exit = IO_READ_1;
					CL_OUT_N: step_exit = IO_WRITE_1;
					default: step_exit = FETCH_1;
				endcase
			end
			OP2_3: begin
				case (c)
					CL_LOAD_ABS8, CL_LOAD_ABS16: step_exit = MEM_READ1_1;
					CL_STORE_ABS8, CL_STORE_ABS16, CL_CALL: step_exit = MEM_WRITE1_1;
					default: step_exit = FETCH_1;
				endcase
			end
			MEM_READ1_3: begin
				case (c)
					CL_LOAD_ABS16, CL_POP: step_exit = PRE_MEM_READ_2;
					CL_RET: step_exit = MEM_READ2_1;
					CL_RMW: step_exit = PRE_MEM_WRITE_1;
					CL_EX_SP: step_exit = MEM_WRITE1_1;
					default: step_exit = FETCH_1;
				endcase
			end
			MEM_READ2_3: begin
				if (c == CL_EX_SP) begin
					step_exit = MEM_WRITE2_1;
				end
			end
			MEM_WRITE1_3: begin
				case (c)
					CL_STORE_ABS16, CL_CALL, CL_PUSH: step_exit = PRE_MEM_WRITE_2;
					CL_EX_SP: step_exit = PRE_MEM_READ_2;
					default: step_exit = FETCH_1;
				endcase
			end
			default: step_exit = FETCH_1;
		endcase
	endfunction

	assign service = int_status.active_int || int_status.active_nmi;
	assign cls     = service ? CL_PUSH : iclass; // Return address push

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			state <= IDLE;
		end else if (take.nmi) begin
			state <= ACK_NMI_1;
		end else if (take.intr) begin
			state <= ACK_INT_1;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next  = IDLE;
		seq_ctl     = '0;
		halt.n_halt = 1'b1;
		halt.we     = 1'b0;
		case (state)
			IDLE: state_next = ipram_loaded ? FETCH_1 : IDLE;
			FETCH_1, OP1_1, OP2_1, MEM_READ1_1, MEM_READ2_1, MEM_WRITE1_1,
			MEM_WRITE2_1, IO_READ_1, IO_WRITE_1, ACK_INT_1, ACK_INT_2, ACK_INT_3,
			ACK_NMI_1: state_next = state_e'(state + 6'd1);
			FETCH_2: begin
				state_next     = FETCH_3;
				seq_ctl.sample = 1'b1;
			end
			OP1_2, OP2_2, MEM_READ1_2, MEM_READ2_2, MEM_WRITE1_2, MEM_WRITE2_2,
			IO_READ_2, IO_WRITE_2: begin
				state_next     = state_e'(state + 6'd1);
				seq_ctl.sample = !service && (step_exit(state_next, cls) == FETCH_1);
			end
			FETCH_3, OP1_3, OP2_3, MEM_READ1_3, MEM_READ2_3, MEM_WRITE1_3,
			MEM_WRITE2_3, IO_READ_3, IO_WRITE_3: begin
				state_next       = step_exit(state, cls);
				seq_ctl.suppress = (state_next != FETCH_1) && (state_next != PRE_FETCH);
				seq_ctl.done     = service && (state == MEM_WRITE2_3);
				if (state == FETCH_3 && cls == CL_HALT) begin
					halt.we     = 1'b1;
					halt.n_halt = int_status.sampled_int; // Leave halt at once if INT pending
				end
			end
			ACK_INT_4: begin
				if (int_status.mode == IM1) begin
					state_next = PRE_MEM_WRITE_1; // RST 38h push
				end else begin
					state_next   = FETCH_3; // Opcode comes from the data bus
					seq_ctl.done = 1'b1;
				end
			end
			ACK_NMI_2: state_next = PRE_MEM_WRITE_1;
			PRE_FETCH: state_next = FETCH_1;
			PRE_MEM_READ_2: state_next = MEM_READ2_1;
			PRE_MEM_WRITE_1: state_next = MEM_WRITE1_1;
			PRE_MEM_WRITE_2: state_next = MEM_WRITE2_1;
			default: state_next = IDLE;
		endcase
	end

	assert property (@(posedge clk) disable iff (!n_reset)
		!$isunknown(state) && (state <= PRE_MEM_WRITE_2));

endmodule

// File: rtl/int_controller.sv
`timescale 1ns/1ps

module int_controller (
	input  logic                      clk,
	input  logic                      n_reset,
	input  cpu_ctrl_pkg::int_ctl_t    int_ctl,
	input  cpu_ctrl_pkg::int_req_t    int_req,
	input  cpu_ctrl_pkg::seq_ctl_t    seq_ctl,
	output cpu_ctrl_pkg::take_t       take,
	output cpu_ctrl_pkg::int_status_t int_status
);
	import cpu_ctrl_pkg::*;

	logic      iff1;
	logic      iff2;
	logic      ei_delay; // Holds INT off across the instruction after EI
	logic      sampled_int;
	logic      sampled_nmi;
	logic      active_int;
	logic      active_nmi;
	int_mode_e mode;
	logic      boundary;

	// Sampled flags only live in the state after a sample
	assign boundary  = !seq_ctl.sample && !seq_ctl.suppress;
	assign take.nmi  = boundary && sampled_nmi;
	assign take.intr = boundary && sampled_int && !sampled_nmi &&
		!int_ctl.dis && !int_ctl.enable;

	assign int_status.active_int  = active_int;
	assign int_status.active_nmi  = active_nmi;
	assign int_status.iff2        = iff2;
	assign int_status.sampled_int = sampled_int;
	assign int_status.sampled_nmi = sampled_nmi;
	assign int_status.mode        = mode;

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			sampled_nmi <= 1'b0;
			sampled_int <= 1'b0;
		end else if (seq_ctl.sample) begin
			sampled_nmi <= int_req.nmi;
			sampled_int <= !int_req.nmi && iff1 && !ei_delay && int_req.intr; // NMI first
		end else begin
			sampled_nmi <= 1'b0;
			sampled_int <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			ei_delay <= 1'b0;
		end else if (int_ctl.enable) begin
			ei_delay <= 1'b1;
		end else if (seq_ctl.sample) begin
			ei_delay <= 1'b0; // Next sample point may accept INT
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			iff1 <= 1'b0;
			iff2 <= 1'b0;
		end else if (int_ctl.dis) begin
			iff1 <= 1'b0;
			iff2 <= 1'b0;
		end else if (int_ctl.enable) begin
			iff1 <= 1'b1;
			iff2 <= 1'b1;
		end else if (int_ctl.restore) begin
			iff1 <= iff2;
		end else if (take.nmi) begin
			iff2 <= iff1; // Saved for RETN
			iff1 <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			active_int <= 1'b0;
			active_nmi <= 1'b0;
		end else if (take.nmi) begin
			active_nmi <= 1'b1;
		end else if (take.intr) begin
			active_int <= 1'b1;
		end else if (seq_ctl.done) begin
			active_int <= 1'b0;
			active_nmi <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge n_reset) begin
		if (!n_reset) begin
			mode <= IM0;
		end else if (int_ctl.mode_change) begin
			mode <= int_ctl.mode_next;
		end
	end

	assert property (@(posedge clk) disable iff (!n_reset) !(active_int && active_nmi));

	assert property (@(posedge clk) disable iff (!n_reset) !(sampled_int && sampled_nmi));

	assert property (@(posedge clk) disable iff (!n_reset)
		int_ctl.mode_change |-> (int_ctl.mode_next inside {IM0, IM1}));

endmodule

// File: rtl/op_decoder.sv
`timescale 1ns/1ps

module op_decoder (
	input  cpu_ctrl_pkg::instr_u       instr,
	input  cpu_ctrl_pkg::flags_t       flags,
	output cpu_ctrl_pkg::instr_class_e iclass
);
	import cpu_ctrl_pkg::*;

	logic cond; // Condition of CALL cc and RET cc holds

	always_comb begin
		case (instr.xyz.y)
			3'd0: cond = !flags.z;  // NZ
			3'd1: cond = flags.z;   // Z
			3'd2: cond = !flags.c;  // NC
			3'd3: cond = flags.c;   // C
			3'd4: cond = !flags.pv; // PO
			3'd5: cond = flags.pv;  // PE
			3'd6: cond = !flags.s;  // P
			default: cond = flags.s; // M
		endcase
	end

	// Prefix bytes and all register-only opcodes stay CL_SIMPLE
	always_comb begin
		iclass = CL_SIMPLE;
		case (instr.xyz.x)
			2'd0: begin
				case (instr.xyz.z)
					3'd0: begin
						if (instr.xyz.y >= 3'd2) begin
							iclass = CL_IMM8; // DJNZ e, JR e, JR cc,e
						end
					end
					3'd1: begin
						if (!instr.xpqz.q) begin
							iclass = CL_IMM16; // LD dd,nn
						end
					end
					3'd2: begin
						case (instr.xpqz.p)
							2'd2: begin
								if (instr.xpqz.q) begin
									iclass = CL_LOAD_ABS16; // LD HL,(nn)
								end else begin
									iclass = CL_STORE_ABS16; // LD (nn),HL
								end
							end
							2'd3: begin
								if (instr.xpqz.q) begin
									iclass = CL_LOAD_ABS8; // LD A,(nn)
								end else begin
									iclass = CL_STORE_ABS8; // LD (nn),A
								end
							end
							default: begin
								if (instr.xpqz.q) begin
									iclass = CL_READ8; // LD A,(BC) or (DE)
								end else begin
									iclass = CL_WRITE8; // LD (BC) or (DE),A
								end
							end
						endcase
					end
					3'd4, 3'd5: begin
						if (instr.xyz.y == 3'd6) begin
							iclass = CL_RMW; // INC (HL), DEC (HL)
						end
					end
					3'd6: begin
						if (instr.xyz.y == 3'd6) begin
							iclass = CL_LD_MEM_IMM; // LD (HL),n before LD r,n
						end else begin
							iclass = CL_IMM8;
						end
					end
					default: iclass = CL_SIMPLE;
				endcase
			end
			2'd1: begin
				if (instr.raw == 8'h76) begin
					iclass = CL_HALT; // Sits in the LD (HL),(HL) slot
				end else if (instr.xyz.z == 3'd6) begin
					iclass = CL_READ8; // LD r,(HL)
				end else if (instr.xyz.y == 3'd6) begin
					iclass = CL_WRITE8; // LD (HL),r
				end
			end
			2'd2: begin
				if (instr.xyz.z == 3'd6) begin
					iclass = CL_READ8; // ALU op A,(HL)
				end
			end
			default: begin
				case (instr.xyz.z)
					3'd0: begin
						if (cond) begin
							iclass = CL_RET; // RET cc taken
						end
					end
					3'd1: begin
						if (!instr.xpqz.q) begin
							iclass = CL_POP;
						end else if (instr.xpqz.p == 2'd0) begin
							iclass = CL_RET;
						end
					end
					3'd2: iclass = CL_IMM16; // JP cc,nn
					3'd3: begin
						case (instr.xyz.y)
							3'd0: iclass = CL_IMM16; // JP nn
							3'd2: iclass = CL_OUT_N;
							3'd3: iclass = CL_IN_N;
							3'd4: iclass = CL_EX_SP;
							default: iclass = CL_SIMPLE;
						endcase
					end
					3'd4: begin
						if (cond) begin
							iclass = CL_CALL;
						end else begin
							iclass = CL_SKIP_CALL; // Operands skipped in one extra clock
						end
					end
					3'd5: begin
						if (!instr.xpqz.q) begin
							iclass = CL_PUSH;
						end else if (instr.xpqz.p == 2'd0) begin
							iclass = CL_CALL; // CALL nn
						end
					end
					3'd6: iclass = CL_IMM8; // ALU op A,n
					default: iclass = CL_PUSH; // RST p
				endcase
			end
		endcase
	end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module cpu_ctrl_tb &&
./obj_dir/Vcpu_ctrl_tb || exit 1

// File: src.f
+incdir+test
rtl/cpu_ctrl_pkg.sv
rtl/op_decoder.sv
rtl/cycle_sequencer.sv
rtl/int_controller.sv
rtl/cpu_ctrl.sv
test/cpu_ctrl_tb.sv

// File: test/cpu_ctrl_model.svh
`ifndef CPU_CTRL_MODEL_SVH
`define CPU_CTRL_MODEL_SVH

// Condition codes NZ Z NC C PO PE P M, indexed by the y field
function automatic logic cond_holds(input logic [2:0] cc, input flags_t f);
	logic [7:0] truth;
	truth = {f.s, ~f.s, f.pv, ~f.pv, f.c, ~f.c, f.z, ~f.z};
	return truth[cc];
endfunction

function automatic instr_class_e expected_class(input logic [7:0] op, input flags_t f);
	logic taken;
	taken = cond_holds(op[5:3], f);
	casez (op)
		8'h76: expected_class = CL_HALT;
		8'h10, 8'h18, 8'h20, 8'h28, 8'h30, 8'h38: expected_class = CL_IMM8; // DJNZ, JR
		8'b00??_0001: expected_class = CL_IMM16;
		8'h02, 8'h12: expected_class = CL_WRITE8;
		8'h0A, 8'h1A: expected_class = CL_READ8;
		8'h22: expected_class = CL_STORE_ABS16;
		8'h2A: expected_class = CL_LOAD_ABS16;
		8'h32: expected_class = CL_STORE_ABS8;
		8'h3A: expected_class = CL_LOAD_ABS8;
		8'h34, 8'h35: expected_class = CL_RMW;
		8'h36: expected_class = CL_LD_MEM_IMM;
		8'b00??_?110: expected_class = CL_IMM8; // LD r,n
		8'b01??_?110: expected_class = CL_READ8;
		8'b0111_0???: expected_class = CL_WRITE8; // LD (HL),r
		8'b10??_?110: expected_class = CL_READ8;
		8'b11??_?000: expected_class = taken ? CL_RET : CL_SIMPLE;
		8'hC9: expected_class = CL_RET;
		8'b11??_0001: expected_class = CL_POP;
		8'b11??_?010, 8'hC3: expected_class = CL_IMM16;
		8'hD3: expected_class = CL_OUT_N;
		8'hDB: expected_class = CL_IN_N;
		8'hE3: expected_class = CL_EX_SP;
		8'b11??_?100: expected_class = taken ? CL_CALL : CL_SKIP_CALL;
		8'hCD: expected_class = CL_CALL;
		8'b11??_0101: expected_class = CL_PUSH;
		8'b11??_?110: expected_class = CL_IMM8;
		8'b11??_?111: expected_class = CL_PUSH; // RST
		default: expected_class = CL_SIMPLE;
	endcase
endfunction

// Clocks from FETCH_1 to the next FETCH_1
function automatic int path_clocks(input instr_class_e cls);
	case (cls)
		CL_SKIP_CALL: path_clocks = 4;
		CL_IMM8, CL_READ8, CL_WRITE8: path_clocks = 6;
		CL_IMM16, CL_LD_MEM_IMM, CL_IN_N, CL_OUT_N, CL_RET: path_clocks = 9;
		CL_POP, CL_RMW: path_clocks = 10;
		CL_PUSH: path_clocks = 11;
		CL_LOAD_ABS8, CL_STORE_ABS8: path_clocks = 12;
		CL_LOAD_ABS16, CL_STORE_ABS16, CL_CALL, CL_EX_SP: path_clocks = 16;
		default: path_clocks = 3;
	endcase
endfunction

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

`endif

// File: test/cpu_ctrl_tb.sv
`timescale 1ns/1ps

module cpu_ctrl_tb;
	import cpu_ctrl_pkg::*;

	`include "cpu_ctrl_model.svh"

	localparam int TIMEOUT = 64; // Clocks, longer than any instruction with service

	logic        clk;
	logic        n_reset;
	logic        ipram_loaded;
	int_ctl_t    int_ctl;
	int_req_t    int_req;
	instr_u      instr;
	flags_t      flags;
	halt_t       halt;
	int_status_t int_status;
	state_e      state;

	logic [31:0] seed;
	int          exp_len_q[$]; // One entry per issued opcode
	int          span;         // Clocks since the last FETCH_1

	cpu_ctrl dut0 (
		.clk          (clk),
		.n_reset      (n_reset),
		.ipram_loaded (ipram_loaded),
		.int_ctl      (int_ctl),
		.int_req      (int_req),
		.instr        (instr),
		.flags        (flags),
		.halt         (halt),
		.int_status   (int_status),
		.state        (state)
	);

	always #50 clk = ~clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic state_matches(input string name, input state_e got, input state_e exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAIL at time %0t %s got %s expected %s",
				$time, name, got.name(), exp.name()));
		end
	endtask

	task automatic halt_matches(input string name, input halt_t got, input halt_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAIL at time %0t %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic status_matches(input string name, input int_status_t got,
		input int_status_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("FAIL at time %0t %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic length_matches(input string name, input int got, input int exp);
		if (got != exp) begin
			stop_with_error($sformatf("FAIL at time %0t %s got %0d expected %0d",
				$time, name, got, exp));
		end
	endtask

	// Sampled flags are expected low wherever status is checked
	function automatic int_status_t make_status(input logic act_int, input logic act_nmi,
		input logic iff2, input int_mode_e mode);
		int_status_t s;
		s            = '0;
		s.active_int = act_int;
		s.active_nmi = act_nmi;
		s.iff2       = iff2;
		s.mode       = mode;
		return s;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic wait_for_state(input state_e s);
		int n;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (state != s && n < TIMEOUT);
		if (state != s) begin
			stop_with_error($sformatf("Timed out waiting for state %s", s.name()));
		end
	endtask

	// New opcode goes out in FETCH_2, extra covers interrupt service in the span
	task automatic issue_op(input logic [7:0] op, input flags_t f, input int extra);
		wait_for_state(FETCH_2);
		instr.raw = op;
		flags     = f;
		exp_len_q.push_back(path_clocks(expected_class(op, f)) + extra);
	endtask

	// NOP with an NMI pulse, iff2 should then hold the former IFF1
	task automatic run_nmi(input logic exp_iff2);
		issue_op(8'h00, '0, 10);
		int_req.nmi = 1'b1;
		next_cycle();
		int_req.nmi = 1'b0;
		wait_for_state(ACK_NMI_1);
		status_matches("int_status", int_status, make_status(1'b0, 1'b1, exp_iff2, IM0));
		wait_for_state(FETCH_1);
		status_matches("int_status", int_status, make_status(1'b0, 1'b0, exp_iff2, IM0));
	endtask

	// Times each FETCH_1 to FETCH_1 span
	always @(negedge clk) begin
		if (state == FETCH_1) begin
			if (exp_len_q.size() > 0) begin
				length_matches("cycle length", span, exp_len_q.pop_front());
			end
			span = 1;
		end else begin
			span = span + 1;
		end
	end

	initial begin
		int i;
		clk          = 1'b0;
		n_reset      = 1'b0;
		ipram_loaded = 1'b0;
		int_ctl      = '0;
		int_req      = '0;
		instr.raw    = 8'h00;
		flags        = '0;
		seed         = 32'h5f230d4d;
		span         = 0;
		repeat (3) @(posedge clk);
		#1;
		n_reset = 1'b1;

		state_matches("state", state, IDLE);
		halt_matches("halt", halt, halt_t'(2'b10));
		status_matches("int_status", int_status, make_status(1'b0, 1'b0, 1'b0, IM0));
		repeat (3) begin
			next_cycle();
			state_matches("state", state, IDLE); // Program RAM not loaded yet
		end
		ipram_loaded = 1'b1;
		next_cycle();
		state_matches("state", state, FETCH_1);

		for (i = 0; i < 300; i++) begin
			seed = lcg_next(seed);
			issue_op(seed[31:24], flags_t'(seed[19:16]), 0);
		end

		issue_op(8'h76, '0, 0);
		halt_matches("halt", halt, halt_t'(2'b10));
		next_cycle();
		halt_matches("halt", halt, halt_t'(2'b01)); // FETCH_3 strobe
		next_cycle();
		halt_matches("halt", halt, halt_t'(2'b10));

		issue_op(8'hFB, '0, 0); // EI sets both flip-flops
		int_ctl.enable = 1'b1;
		next_cycle();
		int_ctl = '0;
		run_nmi(1'b1);

		int_req.intr = 1'b1; // IFF1 cleared by NMI, held INT must wait
		issue_op(8'h00, '0, 0);
		int_ctl.restore = 1'b1;
		next_cycle();
		int_ctl = '0;
		issue_op(8'h00, '0, 5); // Mode 0 adds ACK_INT_1..4 and FETCH_3
		wait_for_state(ACK_INT_1);
		status_matches("int_status", int_status, make_status(1'b1, 1'b0, 1'b1, IM0));
		int_req.intr = 1'b0;
		next_cycle();
		state_matches("state", state, ACK_INT_2);
		next_cycle();
		state_matches("state", state, ACK_INT_3);
		next_cycle();
		state_matches("state", state, ACK_INT_4);
		next_cycle();
		state_matches("state", state, FETCH_3);
		status_matches("int_status", int_status, make_status(1'b0, 1'b0, 1'b1, IM0));

		run_nmi(1'b1);
		run_nmi(1'b0); // IFF1 was already clear

		issue_op(8'hF3, '0, 0); // DI
		int_ctl.dis = 1'b1;
		next_cycle();
		int_ctl      = '0;
		int_req.intr = 1'b1;
		issue_op(8'hFB, '0, 0); // EI with IM 1
		int_ctl.enable      = 1'b1;
		int_ctl.mode_change = 1'b1;
		int_ctl.mode_next   = IM1;
		next_cycle();
		int_ctl = '0;
		issue_op(8'h00, '0, 0); // Still held off by the EI delay
		issue_op(8'h00, '0, 12);
		wait_for_state(ACK_INT_1);
		status_matches("int_status", int_status, make_status(1'b1, 1'b0, 1'b1, IM1));
		int_req.intr = 1'b0;
		wait_for_state(FETCH_1);
		status_matches("int_status", int_status, make_status(1'b0, 1'b0, 1'b1, IM1));

		issue_op(8'hF3, '0, 0);
		int_ctl.dis = 1'b1;
		next_cycle();
		int_ctl      = '0;
		int_req.intr = 1'b1;
		for (i = 0; i < 6; i++) begin
			seed = lcg_next(seed);
			issue_op(seed[31:24], flags_t'(seed[19:16]), 0);
		end
		int_req.intr = 1'b0;

		wait_for_state(FETCH_1);
		@(negedge clk);
		#1;
		if (exp_len_q.size() != 0) begin
			stop_with_error("Cycle length checks were still pending at the end of the run");
		end else begin
			$display("Finished with no errors");
		end
		$finish;
	end

endmodule
